// ==== dda_timer.sv ====
`timescale 1ns/1ns

module dda_timer #(
  parameter int BUFFER_BITS = 2
) (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  motion_pkg::divisor_t          clock_divisor,
  input  logic                          halt_n,        // Active low, level
  input  motion_pkg::move_t             slot_move,     // Segment at move_index
  input  logic [(1<<BUFFER_BITS)-1:0]   stepready,
  input  logic [BUFFER_BITS-1:0]        wr_index,
  output logic [BUFFER_BITS-1:0]        move_index,
  output logic [(1<<BUFFER_BITS)-1:0]   stepfinished,
  output logic                          step_event,    // One clock per step
  output logic                          step_dir,
  output logic                          move_done      // Last clock of a segment
);
  import motion_pkg::*;

  timer_state_t state;

  // Control counters
  divisor_t  tick_count; // Clocks left in the current tick
  duration_t remaining;  // Ticks left after this one
  accum_t    accum;      // Phase, carried across segments

  // Segment payload
  rate_t rate;
  rate_t rate_delta;
  logic  seg_dir;

  logic   slot_busy; // stepready and stepfinished differ
  logic   load;
  logic   tick;
  logic   last_tick;
  logic   fire;
  accum_t accum_sum;

  // Ownership test on the slot under the cursor
  assign slot_busy = stepready[move_index] ^ stepfinished[move_index];

  assign load = (state == IDLE_LOAD) && slot_busy && halt_n;

  // Tick when the divider runs out, halt masks it
  assign tick      = (state == EXECUTE) && (tick_count == '0) && halt_n;
  assign last_tick = tick && (remaining == '0);

  // Sign-extended sum, 40 bits
  assign accum_sum = accum + rate;
  assign fire      = tick && (accum_sum >= STEP_THRESHOLD);

  assign step_event = fire;      // Same clock as the tick
  assign step_dir   = seg_dir;
  assign move_done  = last_tick;

  // Rate integration and segment capture
  always_ff @(posedge CLK) begin
    if (load) begin
      rate       <= slot_move.rate;
      rate_delta <= slot_move.rate_delta;
      seg_dir    <= slot_move.dir;
    end else if (tick) begin
      rate <= rate + rate_delta; // Acceleration per tick
    end
  end

  // FSM, divider, countdown, accumulator and slot release
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state        <= IDLE_LOAD;
      move_index   <= '0;
      stepfinished <= '0;
      tick_count   <= '0;
      remaining    <= '0;
      accum        <= '0;
    end else if (!halt_n) begin
      // Drop the queue and follow the writer
      move_index   <= wr_index;
      stepfinished <= stepready;   // Every slot reads as free
      state        <= IDLE_LOAD;
    end else begin
      case (state)
        IDLE_LOAD: begin
          if (slot_busy) begin
            tick_count <= clock_divisor;
            remaining  <= slot_move.duration;
            state      <= EXECUTE;
          end
        end
        EXECUTE: begin
          if (tick) begin
            tick_count <= clock_divisor; // Reload divider
            // Take one threshold out per step
            if (fire) begin
              accum <= accum_sum - STEP_THRESHOLD;
            end else begin
              accum <= accum_sum;
            end
            if (last_tick) begin
              // Hand the slot back and move on
              stepfinished[move_index] <= ~stepfinished[move_index];
              move_index               <= move_index + 1'b1;
              state                    <= IDLE_LOAD;
            end else begin
              remaining <= remaining - 1'b1;
            end
          end else begin
            tick_count <= tick_count - 1'b1;
          end
        end
        default: state <= IDLE_LOAD;
      endcase
    end
  end

endmodule

// ==== motion_pkg.sv ====
package motion_pkg;

  // Tick count of one segment, segment runs duration + 1 ticks
  typedef logic [31:0] duration_t;

  // Signed phase increment per tick, also used for the rate change
  typedef logic signed [31:0] rate_t;

  // Phase accumulator, wide enough that rate sums never wrap
  typedef logic signed [39:0] accum_t;

  // Clock divisor, tick is divisor + 1 clocks
  typedef logic [7:0] divisor_t;

  // Signed step position
  typedef logic signed [31:0] position_t;

  // Step fires at 2^24 phase units
  localparam accum_t STEP_THRESHOLD = accum_t'(1) << 24;

  // One move segment as the host writes it, 97 bits
  typedef struct packed {
    duration_t duration;   // Ticks minus one
    rate_t     rate;       // Starting rate
    rate_t     rate_delta; // Added to rate every tick
    logic      dir;        // 1 = positive
  } move_t;

  // Timer FSM
  // IDLE_LOAD waits for an occupied slot, EXECUTE runs the segment
  typedef enum logic [0:0] {
    IDLE_LOAD = 1'b0,
    EXECUTE   = 1'b1
  } timer_state_t;

endpackage

// ==== motion_top.sv ====
`timescale 1ns/1ns

module motion_top #(
  parameter int BUFFER_BITS  = 2, // 4 slots
  parameter int PULSE_CYCLES = 3
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  motion_pkg::move_t     wr_move,
  input  motion_pkg::divisor_t  clock_divisor,
  input  logic                  halt_n,
  output logic                  buffer_full,
  output logic                  step,
  output logic                  dir,
  output motion_pkg::position_t position,
  output logic                  move_done
);
  import motion_pkg::*;

  // Buffer to timer
  move_t                         slot_move;
  logic [(1<<BUFFER_BITS)-1:0]   stepready;
  logic [BUFFER_BITS-1:0]        wr_index;

  // Timer back to buffer
  logic [BUFFER_BITS-1:0]        move_index;
  logic [(1<<BUFFER_BITS)-1:0]   stepfinished;

  // Timer to step generator
  logic step_event;
  logic step_dir;

  move_buffer #(.BUFFER_BITS(BUFFER_BITS)) u_buffer (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .wr_en        (wr_en),
    .wr_move      (wr_move),
    .move_index   (move_index),
    .stepfinished (stepfinished),
    .slot_move    (slot_move),
    .stepready    (stepready),
    .wr_index     (wr_index),
    .buffer_full  (buffer_full)
  );

  dda_timer #(.BUFFER_BITS(BUFFER_BITS)) u_timer (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .clock_divisor (clock_divisor),
    .halt_n        (halt_n),
    .slot_move     (slot_move),
    .stepready     (stepready),
    .wr_index      (wr_index),
    .move_index    (move_index),
    .stepfinished  (stepfinished),
    .step_event    (step_event),
    .step_dir      (step_dir),
    .move_done     (move_done)
  );

  step_generator #(.PULSE_CYCLES(PULSE_CYCLES)) u_stepgen (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .step_event (step_event),
    .step_dir   (step_dir),
    .step       (step),
    .dir        (dir),
    .position   (position)
  );

endmodule

// ==== move_buffer.sv ====
`timescale 1ns/1ns

module move_buffer #(
  parameter int BUFFER_BITS = 2 // Index width, 2^BUFFER_BITS slots
) (
  input  logic                          CLK,
  input  logic                          rst_n,
  input  logic                          wr_en,        // One-cycle write strobe
  input  motion_pkg::move_t             wr_move,
  input  logic [BUFFER_BITS-1:0]        move_index,   // Timer read cursor
  input  logic [(1<<BUFFER_BITS)-1:0]   stepfinished, // Toggled by the timer
  output motion_pkg::move_t             slot_move,
  output logic [(1<<BUFFER_BITS)-1:0]   stepready,    // Toggled here on write
  output logic [BUFFER_BITS-1:0]        wr_index,
  output logic                          buffer_full
);
  import motion_pkg::*;

  localparam int SLOTS = 1 << BUFFER_BITS;

  // Segment storage
  move_t slots [SLOTS];

  logic                   accept;     // Write taken this clock
  logic [SLOTS-1:0]       ready_next;
  logic [BUFFER_BITS-1:0] index_next;

  // Writes while full are dropped
  assign accept = wr_en && !buffer_full;

  // Next toggle vector and cursor
  always_comb begin
    ready_next = stepready;
    index_next = wr_index;
    if (accept) begin
      ready_next[wr_index] = ~stepready[wr_index]; // Slot becomes occupied
      index_next           = wr_index + 1'b1;      // Wraps at SLOTS
    end
  end

  // Payload only
  always_ff @(posedge CLK) begin
    if (accept) begin
      slots[wr_index] <= wr_move;
    end
  end

  // Timer sees its slot without a read cycle
  assign slot_move = slots[move_index];

  // Cursor, ownership bits and full flag
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      stepready   <= '0;
      wr_index    <= '0;
      buffer_full <= 1'b0;
    end else begin
      stepready <= ready_next;
      wr_index  <= index_next;
      // Full when the next slot to write is still owned by the timer
      // Lags a finish by one clock, never a write
      buffer_full <= ready_next[index_next] ^ stepfinished[index_next];
    end
  end

endmodule

// ==== step_generator.sv ====
`timescale 1ns/1ns

module step_generator #(
  parameter int PULSE_CYCLES = 3 // Step pulse width in clocks
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  step_event, // One clock per step
  input  logic                  step_dir,   // 1 = positive
  output logic                  step,
  output logic                  dir,
  output motion_pkg::position_t position
);
  import motion_pkg::*;

  localparam int CNT_BITS = $clog2(PULSE_CYCLES + 1);

  logic [CNT_BITS-1:0] pulse_count; // Clocks of pulse still to go
  position_t           step_delta;

  // +1 or -1
  assign step_delta = step_dir ? position_t'(1) : -position_t'(1);

  // High while the counter runs
  assign step = (pulse_count != '0);

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      pulse_count <= '0;
      dir         <= 1'b0;
      position    <= '0;
    end else begin
      if (step_event) begin
        // A new step restarts the pulse
        pulse_count <= CNT_BITS'(PULSE_CYCLES);
        dir         <= step_dir;
        position    <= position + step_delta; // Every step counts
      end else if (step) begin
        pulse_count <= pulse_count - 1'b1;
      end
    end
  end

endmodule

// ==== tb_motion_top.sv ====
`timescale 1ns/1ns

module tb_motion_top;
  import motion_pkg::*;

  localparam int     PULSE  = 3;                   // UUT default pulse width
  localparam longint THRESH = longint'(1) << 24;   // Step threshold of 2^24

  // Expected result of one segment
  typedef struct packed {
    int        load_at;   // Clock in which the timer loads it
    int        done_at;   // Clock of move_done
    int        div;
    int        edges;     // Step rising edges
    int        ev_start;  // Last event clock before the segment
    longint    acc_start;
    position_t pos_start;
    position_t pos_end;
    logic      dir_start;
    logic      dir_end;
    move_t     mv;
  } segment_exp_t;

  logic      CLK;
  logic      rst_n;
  logic      wr_en;
  move_t     wr_move;
  divisor_t  clock_divisor;
  logic      halt_n;
  logic      buffer_full;
  logic      step;
  logic      dir;
  position_t position;
  logic      move_done;

  integer seed = 32'h409a0183;
  int     cycle = 0;
  int     budget = 300;  // Watchdog limit in clocks, raised per predicted segment

  // Reference model state
  segment_exp_t q[$];
  longint       acc = 0;
  position_t    pos_m = 0;
  logic         dir_m = 1'b0;
  int           last_event = -100;
  int           last_done = 0;

  // Monitor state
  logic         step_q = 1'b0;
  position_t    pos_q = 0;
  int           edge_cnt = 0;
  int           run_len = 0;
  int           run_steps = 0;
  logic         check_next = 1'b0;
  logic         exp_done;
  segment_exp_t fin;

  motion_top UUT (
    .CLK(CLK), .rst_n(rst_n), .wr_en(wr_en), .wr_move(wr_move),
    .clock_divisor(clock_divisor), .halt_n(halt_n), .buffer_full(buffer_full),
    .step(step), .dir(dir), .position(position), .move_done(move_done)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  always @(posedge CLK) cycle <= cycle + 1;  // Clock index

  task automatic report_failure(input string msg);
    $display("Errors found");
    $fatal(1, "%s", msg);
  endtask

  task automatic check_equal(input string name, input longint exp, input longint got);
    assert (exp == got)
      else report_failure($sformatf("mismatch %s expected %h got %h", name, exp, got));
  endtask

  // Integrates the ticks before limit and returns the new step edges
  function automatic int integrate_ticks(input segment_exp_t e, input int limit);
    int     i;
    int     t;
    int     n;
    longint r;
    n = 0;
    r = e.mv.rate;
    for (i = 0; i <= int'(e.mv.duration); i++) begin
      t = e.load_at + (i + 1) * (e.div + 1);  // Clock of tick i
      if (t < limit) begin
        acc = acc + r;
        r = r + e.mv.rate_delta;
        if (acc >= THRESH) begin
          acc = acc - THRESH;
          pos_m = pos_m + (e.mv.dir ? 1 : -1);
          dir_m = e.mv.dir;
          if (t - last_event > PULSE) n++;  // Otherwise the pulse restarts
          last_event = t;
        end
      end
    end
    return n;
  endfunction

  task automatic predict_segment(input move_t m, input int w);
    segment_exp_t e;
    e.mv = m;
    e.div = int'(clock_divisor);
    e.load_at = (w > last_done) ? w + 1 : last_done + 1;  // Waits for the previous one
    e.done_at = e.load_at + (int'(m.duration) + 1) * (e.div + 1);
    e.acc_start = acc;
    e.pos_start = pos_m;
    e.dir_start = dir_m;
    e.ev_start = last_event;
    e.edges = integrate_ticks(e, e.done_at + 1);
    e.pos_end = pos_m;
    e.dir_end = dir_m;
    last_done = e.done_at;
    budget = budget + e.done_at - e.load_at + 4;
    q.push_back(e);
  endtask

  task automatic wait_clocks(input int n);
    repeat (n) @(posedge CLK);
    #1;
  endtask

  // One-cycle write that the model sees only when the buffer takes it
  task automatic write_move(input move_t m, input bit taken);
    wr_en = 1'b1;
    wr_move = m;
    if (taken) predict_segment(m, cycle);
    wait_clocks(1);
    wr_en = 1'b0;
  endtask

  task automatic wait_drained();
    while (q.size() != 0) wait_clocks(1);
    wait_clocks(2);  // Last checks and buffer_full settle
  endtask

  task automatic apply_halt(output int edges);
    halt_n = 1'b0;
    edges = 0;
    if (q.size() != 0) begin
      acc = q[0].acc_start;
      pos_m = q[0].pos_start;
      dir_m = q[0].dir_start;
      last_event = q[0].ev_start;
      edges = integrate_ticks(q[0], cycle);  // Ticks from here on are masked
    end
    q.delete();
  endtask

  function automatic move_t make_move(input int d, input longint r, input longint dr,
                                      input logic dr_dir);
    move_t m;
    m.duration = d;
    m.rate = rate_t'(r);
    m.rate_delta = rate_t'(dr);
    m.dir = dr_dir;
    return m;
  endfunction

  function automatic move_t random_move();
    longint r;
    longint dr;
    r = ($unsigned($random(seed)) % (3 * THRESH)) - THRESH / 2;  // Mostly positive
    dr = $random(seed) % (THRESH / 16);
    return make_move($unsigned($random(seed)) % 21, r, dr, 1'($random(seed)));
  endfunction

  // Segment end, step count, pulse width and position
  always @(negedge CLK) begin
    if (rst_n) begin
      if (step && !step_q) edge_cnt = edge_cnt + 1;
      if (step) begin
        run_len = run_len + 1;
        if (position != pos_q) run_steps = run_steps + 1;  // Restarted pulse
      end else if (step_q) begin
        if (run_steps == 1) check_equal("step width", PULSE, run_len);
        run_len = 0;
        run_steps = 0;
      end
      if (check_next) begin
        check_equal("step edges", fin.edges, edge_cnt);
        check_equal("position", fin.pos_end, position);
        check_equal("dir", fin.dir_end, dir);
        edge_cnt = 0;
        check_next = 1'b0;
      end
      exp_done = 1'b0;
      if (q.size() != 0) exp_done = (cycle == q[0].done_at);
      check_equal("move_done", exp_done, move_done);
      if (exp_done) begin
        fin = q.pop_front();
        check_next = 1'b1;  // Last step of the segment shows up next clock
      end
    end
    step_q = step;
    pos_q = position;
  end

  // Halt masks every tick
  assert property (@(posedge CLK) disable iff (!rst_n) !halt_n |-> !move_done)
    else report_failure("move_done pulsed while halt_n was low");

  initial begin
    while (cycle <= budget) @(posedge CLK);
    $display("Errors found");
    $fatal(1, "timeout, segments stopped finishing in time");
  end

  initial begin
    int i;
    int b;
    int halt_edges;
    rst_n = 1'b0;
    wr_en = 1'b0;
    wr_move = '0;
    clock_divisor = '0;
    halt_n = 1'b1;
    repeat (4) @(posedge CLK);
    #1;
    rst_n = 1'b1;
    check_equal("step", 0, step);
    check_equal("move_done", 0, move_done);
    check_equal("buffer_full", 0, buffer_full);
    check_equal("position", 0, position);
    // Single segments on an idle timer
    clock_divisor = 2;
    write_move(make_move(4, THRESH / 2, 0, 1'b1), 1'b1);
    wait_drained();
    clock_divisor = 0;
    write_move(make_move(0, THRESH, 0, 1'b0), 1'b1);
    wait_drained();
    // Queued random segments with one divisor per batch
    for (b = 0; b < 6; b++) begin
      clock_divisor = $unsigned($random(seed)) % 4;
      for (i = 0; i < 4; i++) write_move(random_move(), 1'b1);
      wait_drained();
    end
    // Fill all four slots so the fifth write is lost
    clock_divisor = 1;
    for (i = 0; i < 4; i++) write_move(make_move(6, THRESH / 3, 0, 1'b1), 1'b1);
    check_equal("buffer_full", 1, buffer_full);
    write_move(make_move(2, THRESH, 0, 1'b0), 1'b0);
    wait_drained();
    wait_clocks(20);
    // Halt in the middle of a queue
    clock_divisor = 0;
    for (i = 0; i < 3; i++) write_move(make_move(15, THRESH / 2 + 7, 0, 1'b0), 1'b1);
    wait_clocks(10);
    apply_halt(halt_edges);
    for (i = 0; i < 12; i++) begin
      wait_clocks(1);
      if (i >= PULSE) check_equal("step", 0, step);  // Last pulse has ended
    end
    check_equal("position", pos_m, position);
    check_equal("step edges", halt_edges, edge_cnt);  // Only steps before the halt
    halt_n = 1'b1;
    edge_cnt = 0;       // Fresh count for the next write
    last_done = cycle;
    wait_clocks(6);
    check_equal("position", pos_m, position);
    write_move(make_move(3, THRESH, 0, 1'b1), 1'b1);
    wait_drained();
    check_equal("position", pos_m, position);
    $display("No errors");
    $finish;
  end

endmodule

// ==== verilog.f ====
motion_pkg.sv
move_buffer.sv
dda_timer.sv
step_generator.sv
motion_top.sv
tb_motion_top.sv
